//--- src/chip8_pkg.sv
`default_nettype none

package chip8_pkg;

    // Memory and register sizes
    localparam int ADDR_W      = 12;
    localparam int DATA_W      = 8;
    localparam int NUM_REGS    = 16;
    localparam int STACK_DEPTH = 16;
    // One extra bit so a full stack can be told from an empty one
    localparam int SP_W        = $clog2(STACK_DEPTH) + 1;
    localparam int CARRY_REG   = 15;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] byte_t;
    typedef logic [3:0]        reg_idx_t;

    // Programs start here, below is the interpreter area
    localparam addr_t RESET_PC = 12'h200;

    // Instruction word seen as nibble fields
    typedef struct packed {
        logic [3:0] op;
        reg_idx_t   x;
        reg_idx_t   y;
        logic [3:0] n;
    } instr_reg_s;

    // Same word seen as opcode plus address, kk is the low byte of nnn
    typedef struct packed {
        logic [3:0] op;
        addr_t      nnn;
    } instr_addr_s;

    typedef union packed {
        instr_reg_s  regs;
        instr_addr_s addr;
    } instr_u;

    typedef struct packed {
        addr_t addr;
        byte_t data;
    } mem_wr_s;

    // Store kinds
    localparam logic STORE_BCD   = 1'b0;
    localparam logic STORE_BLOCK = 1'b1;

    typedef struct packed {
        logic     kind;
        addr_t    base;
        reg_idx_t last_idx;
        byte_t    value;
    } store_cmd_s;

    // BCD always writes three digits
    localparam reg_idx_t BCD_LAST_IDX = 4'd2;

    // Fetch FSM states
    localparam logic [1:0] FETCH_HI      = 2'd0;
    localparam logic [1:0] FETCH_LO      = 2'd1;
    localparam logic [1:0] FETCH_PRESENT = 2'd2;

    // Top nibble opcodes
    localparam logic [3:0] OP_SYS   = 4'h0;
    localparam logic [3:0] OP_JP    = 4'h1;
    localparam logic [3:0] OP_CALL  = 4'h2;
    localparam logic [3:0] OP_SE_K  = 4'h3;
    localparam logic [3:0] OP_SNE_K = 4'h4;
    localparam logic [3:0] OP_SE_V  = 4'h5;
    localparam logic [3:0] OP_LD_K  = 4'h6;
    localparam logic [3:0] OP_ADD_K = 4'h7;
    localparam logic [3:0] OP_ALU   = 4'h8;
    localparam logic [3:0] OP_SNE_V = 4'h9;
    localparam logic [3:0] OP_LD_I  = 4'hA;
    localparam logic [3:0] OP_JP_V0 = 4'hB;
    localparam logic [3:0] OP_MISC  = 4'hF;

    // 8xyN sub-ops
    localparam logic [3:0] ALU_LD   = 4'h0;
    localparam logic [3:0] ALU_OR   = 4'h1;
    localparam logic [3:0] ALU_AND  = 4'h2;
    localparam logic [3:0] ALU_XOR  = 4'h3;
    localparam logic [3:0] ALU_ADD  = 4'h4;
    localparam logic [3:0] ALU_SUB  = 4'h5;
    localparam logic [3:0] ALU_SHR  = 4'h6;
    localparam logic [3:0] ALU_SUBN = 4'h7;
    localparam logic [3:0] ALU_SHL  = 4'hE;

    // Fxkk sub-ops and the RET encoding
    localparam byte_t F_ADD_I  = 8'h1E;
    localparam byte_t F_BCD    = 8'h33;
    localparam byte_t F_STORE  = 8'h55;
    localparam addr_t SYS_RET  = 12'h0EE;

endpackage

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
    import chip8_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset_i,
    input  wire addr_t pc_i,
    input  wire logic  pc_load_i,
    output logic       mem_rd_valid_o,
    output addr_t      mem_rd_addr_o,
    input  wire logic  mem_rd_ready_i,
    input  wire byte_t mem_rd_data_i,
    output logic       instr_valid_o,
    output instr_u     instr_o,
    input  wire logic  instr_ready_i
);

    logic [1:0] state_q;
    logic       rd_valid_q;
    addr_t      rd_addr_q;
    logic       instr_valid_q;
    instr_u     instr_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q       <= FETCH_HI;
            rd_valid_q    <= 1'b0;
            instr_valid_q <= 1'b0;
        end else begin
            case (state_q)
                FETCH_HI: begin
                    // First fetch after reset starts from the core PC
                    if (!rd_valid_q) begin
                        rd_valid_q <= 1'b1;
                        rd_addr_q  <= pc_i;
                    end else if (mem_rd_ready_i) begin
                        rd_addr_q <= rd_addr_q + 12'd1;
                        state_q   <= FETCH_LO;
                    end
                end
                FETCH_LO: begin
                    if (mem_rd_ready_i) begin
                        rd_valid_q    <= 1'b0;
                        instr_valid_q <= 1'b1;
                        state_q       <= FETCH_PRESENT;
                    end
                end
                default: begin
                    // Hold the word until the core takes it
                    if (instr_valid_q && instr_ready_i) begin
                        instr_valid_q <= 1'b0;
                    end
                    // New PC known, restart at the high byte
                    if (pc_load_i) begin
                        rd_valid_q <= 1'b1;
                        rd_addr_q  <= pc_i;
                        state_q    <= FETCH_HI;
                    end
                end
            endcase
        end
    end

    // Big endian, high byte comes first
    always_ff @(posedge clk) begin
        if (rd_valid_q && mem_rd_ready_i) begin
            if (state_q == FETCH_HI) begin
                instr_q[15:8] <= mem_rd_data_i;
            end else begin
                instr_q[7:0] <= mem_rd_data_i;
            end
        end
    end

    assign mem_rd_valid_o = rd_valid_q;
    assign mem_rd_addr_o  = rd_addr_q;
    assign instr_valid_o  = instr_valid_q;
    assign instr_o        = instr_q;

    // A pending read keeps its request until memory answers
    a_rd_stable: assert property (@(posedge clk) disable iff (reset_i)
        mem_rd_valid_o && !mem_rd_ready_i |=> mem_rd_valid_o && $stable(mem_rd_addr_o));

endmodule

`default_nettype wire

//--- src/exec_core.sv
`timescale 1ns/1ns
`default_nettype none

module exec_core
    import chip8_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset_i,
    input  wire logic     instr_valid_i,
    input  wire instr_u   instr_i,
    output logic          instr_ready_o,
    output addr_t         pc_o,
    output logic          pc_load_o,
    output logic          store_valid_o,
    output store_cmd_s    store_cmd_o,
    input  wire logic     store_ready_i,
    input  wire logic     store_done_i,
    input  wire reg_idx_t rf_rd_idx_i,
    output byte_t         rf_rd_data_o
);

    // Architectural state
    byte_t           v_q [NUM_REGS];
    addr_t           stack_q [STACK_DEPTH];
    logic [SP_W-1:0] sp_q;
    addr_t           pc_q;
    addr_t           i_q;

    // Sequencing
    logic       busy_q;
    logic       pc_load_q;
    logic       store_valid_q;
    store_cmd_s store_cmd_q;

    // Decoded fields from both views of the word
    logic [3:0]      op;
    reg_idx_t        x;
    byte_t           vx;
    byte_t           vy;
    byte_t           kk;
    addr_t           nnn;
    logic [SP_W-2:0] sp_wr_idx;
    logic [SP_W-2:0] sp_rd_idx;
    logic            accept;
    logic            skip;
    logic            is_call;
    logic            is_ret;
    logic            is_store;
    byte_t           alu_res;
    logic            alu_flag;
    logic            alu_wr;
    logic            alu_wf;

    assign op        = instr_i.regs.op;
    assign x         = instr_i.regs.x;
    assign vx        = v_q[x];
    assign vy        = v_q[instr_i.regs.y];
    assign nnn       = instr_i.addr.nnn;
    assign kk        = nnn[7:0];
    assign sp_wr_idx = sp_q[SP_W-2:0];
    assign sp_rd_idx = sp_wr_idx - 1'b1;

    assign accept   = instr_valid_i && instr_ready_o;
    assign is_call  = (op == OP_CALL);
    assign is_ret   = (op == OP_SYS) && (nnn == SYS_RET);
    assign is_store = (op == OP_MISC) && ((kk == F_BCD) || (kk == F_STORE));

    // 8xyN results, VF is carry or not-borrow or the bit shifted out
    always_comb begin
        alu_res  = vy;
        alu_flag = 1'b0;
        alu_wr   = 1'b1;
        alu_wf   = 1'b0;
        case (instr_i.regs.n)
            ALU_LD:  alu_res = vy;
            ALU_OR:  alu_res = vx | vy;
            ALU_AND: alu_res = vx & vy;
            ALU_XOR: alu_res = vx ^ vy;
            ALU_ADD: begin
                {alu_flag, alu_res} = {1'b0, vx} + {1'b0, vy};
                alu_wf = 1'b1;
            end
            ALU_SUB: begin
                alu_res  = vx - vy;
                alu_flag = (vx >= vy);
                alu_wf   = 1'b1;
            end
            ALU_SHR: begin
                alu_res  = vx >> 1;
                alu_flag = vx[0];
                alu_wf   = 1'b1;
            end
            ALU_SUBN: begin
                alu_res  = vy - vx;
                alu_flag = (vy >= vx);
                alu_wf   = 1'b1;
            end
            ALU_SHL: begin
                alu_res  = vx << 1;
                alu_flag = vx[7];
                alu_wf   = 1'b1;
            end
            // Unused sub-ops do nothing
            default: alu_wr = 1'b0;
        endcase
    end

    // Skip conditions, 5xyN and 9xyN only with N zero
    always_comb begin
        case (op)
            OP_SE_K:  skip = (vx == kk);
            OP_SNE_K: skip = (vx != kk);
            OP_SE_V:  skip = (instr_i.regs.n == 4'h0) && (vx == vy);
            OP_SNE_V: skip = (instr_i.regs.n == 4'h0) && (vx != vy);
            default:  skip = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q          <= RESET_PC;
            sp_q          <= '0;
            i_q           <= '0;
            busy_q        <= 1'b0;
            pc_load_q     <= 1'b0;
            store_valid_q <= 1'b0;
        end else begin
            pc_load_q <= 1'b0;
            if (store_valid_q && store_ready_i) begin
                store_valid_q <= 1'b0;
            end
            // Store finished, Fx55 moves I past the block
            if (busy_q && store_done_i) begin
                busy_q    <= 1'b0;
                pc_load_q <= 1'b1;
                if (store_cmd_q.kind == STORE_BLOCK) begin
                    i_q <= i_q + addr_t'(store_cmd_q.last_idx) + 12'd1;
                end
            end
            if (accept) begin
                pc_q <= skip ? pc_q + 12'd4 : pc_q + 12'd2;
                case (op)
                    OP_SYS: begin
                        if (is_ret) begin
                            pc_q <= stack_q[sp_rd_idx];
                            sp_q <= sp_q - 1'b1;
                        end
                    end
                    OP_JP:    pc_q <= nnn;
                    OP_CALL: begin
                        pc_q <= nnn;
                        sp_q <= sp_q + 1'b1;
                    end
                    OP_LD_I:  i_q <= nnn;
                    OP_JP_V0: pc_q <= nnn + addr_t'(v_q[0]);
                    OP_MISC: begin
                        if (kk == F_ADD_I) begin
                            i_q <= i_q + addr_t'(vx);
                        end
                        if (is_store) begin
                            busy_q        <= 1'b1;
                            store_valid_q <= 1'b1;
                        end
                    end
                    default: ;
                endcase
                // Stores retire later, on store_done
                if (!is_store) begin
                    pc_load_q <= 1'b1;
                end
            end
        end
    end

    // Register file, stack and store payload
    always_ff @(posedge clk) begin
        if (accept) begin
            case (op)
                OP_LD_K:  v_q[x] <= kk;
                OP_ADD_K: v_q[x] <= vx + kk;
                OP_ALU: begin
                    if (alu_wr) begin
                        v_q[x] <= alu_res;
                    end
                    // Flag after Vx so VF holds the flag when x is F
                    if (alu_wf) begin
                        v_q[CARRY_REG] <= byte_t'(alu_flag);
                    end
                end
                OP_CALL:  stack_q[sp_wr_idx] <= pc_q + 12'd2;
                OP_MISC: begin
                    if (is_store) begin
                        store_cmd_q.kind     <= (kk == F_BCD) ? STORE_BCD : STORE_BLOCK;
                        store_cmd_q.base     <= i_q;
                        store_cmd_q.last_idx <= x;
                        store_cmd_q.value    <= vx;
                    end
                end
                default: ;
            endcase
        end
    end

    // Only one instruction in flight
    assign instr_ready_o = !busy_q;
    assign pc_o          = pc_q;
    assign pc_load_o     = pc_load_q;
    assign store_valid_o = store_valid_q;
    assign store_cmd_o   = store_cmd_q;
    // Combinational port for block stores
    assign rf_rd_data_o  = v_q[rf_rd_idx_i];

    // Program must keep CALL and RET balanced within stack limits
    a_no_overflow: assert property (@(posedge clk) disable iff (reset_i)
        accept && is_call |-> sp_q < STACK_DEPTH);
    a_no_underflow: assert property (@(posedge clk) disable iff (reset_i)
        accept && is_ret |-> sp_q != '0);

endmodule

`default_nettype wire

//--- src/store_unit.sv
`timescale 1ns/1ns
`default_nettype none

module store_unit
    import chip8_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       store_valid_i,
    input  wire store_cmd_s store_cmd_i,
    output logic            store_ready_o,
    output logic            store_done_o,
    output reg_idx_t        rf_rd_idx_o,
    input  wire byte_t      rf_rd_data_i,
    output logic            mem_wr_valid_o,
    output mem_wr_s         mem_wr_o,
    input  wire logic       mem_wr_ready_i
);

    logic       active_q;
    logic       done_q;
    reg_idx_t   cnt_q;
    store_cmd_s cmd_q;

    reg_idx_t last_idx;
    byte_t    hundreds;
    byte_t    tens;
    byte_t    ones;
    byte_t    bcd_digit;
    byte_t    wr_data;
    logic     wr_fire;

    // Decimal digits of the latched value
    assign hundreds = cmd_q.value / 8'd100;
    assign tens     = (cmd_q.value / 8'd10) % 8'd10;
    assign ones     = cmd_q.value % 8'd10;

    always_comb begin
        case (cnt_q)
            4'd0:    bcd_digit = hundreds;
            4'd1:    bcd_digit = tens;
            default: bcd_digit = ones;
        endcase
    end

    // BCD writes three bytes, block writes V0 to Vx
    assign last_idx = (cmd_q.kind == STORE_BCD) ? BCD_LAST_IDX : cmd_q.last_idx;
    assign wr_data  = (cmd_q.kind == STORE_BCD) ? bcd_digit : rf_rd_data_i;
    assign wr_fire  = active_q && mem_wr_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
            cnt_q    <= '0;
        end else begin
            done_q <= 1'b0;
            if (!active_q && store_valid_i) begin
                active_q <= 1'b1;
                cnt_q    <= '0;
            end else if (wr_fire) begin
                // Done pulse follows the last accepted write
                if (cnt_q == last_idx) begin
                    active_q <= 1'b0;
                    done_q   <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active_q && store_valid_i) begin
            cmd_q <= store_cmd_i;
        end
    end

    assign store_ready_o  = !active_q;
    assign store_done_o   = done_q;
    assign rf_rd_idx_o    = cnt_q;
    assign mem_wr_valid_o = active_q;
    // Ascending addresses from I
    assign mem_wr_o       = '{addr: cmd_q.base + addr_t'(cnt_q), data: wr_data};

    // Write request held while memory stalls
    a_wr_stable: assert property (@(posedge clk) disable iff (reset_i)
        mem_wr_valid_o && !mem_wr_ready_i |=> mem_wr_valid_o && $stable(mem_wr_o));

endmodule

`default_nettype wire

//--- src/chip8_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module chip8_cpu
    import chip8_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset_i,
    output logic       mem_rd_valid_o,
    output addr_t      mem_rd_addr_o,
    input  wire logic  mem_rd_ready_i,
    input  wire byte_t mem_rd_data_i,
    output logic       mem_wr_valid_o,
    output mem_wr_s    mem_wr_o,
    input  wire logic  mem_wr_ready_i
);

    // Fetch to execute
    addr_t  pc;
    logic   pc_load;
    logic   instr_valid;
    logic   instr_ready;
    instr_u instr;

    // Execute to store
    logic       store_valid;
    logic       store_ready;
    logic       store_done;
    store_cmd_s store_cmd;
    reg_idx_t   rf_rd_idx;
    byte_t      rf_rd_data;

    fetch_unit u_fetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .pc_i           (pc),
        .pc_load_i      (pc_load),
        .mem_rd_valid_o (mem_rd_valid_o),
        .mem_rd_addr_o  (mem_rd_addr_o),
        .mem_rd_ready_i (mem_rd_ready_i),
        .mem_rd_data_i  (mem_rd_data_i),
        .instr_valid_o  (instr_valid),
        .instr_o        (instr),
        .instr_ready_i  (instr_ready)
    );

    exec_core u_exec (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .instr_ready_o (instr_ready),
        .pc_o          (pc),
        .pc_load_o     (pc_load),
        .store_valid_o (store_valid),
        .store_cmd_o   (store_cmd),
        .store_ready_i (store_ready),
        .store_done_i  (store_done),
        .rf_rd_idx_i   (rf_rd_idx),
        .rf_rd_data_o  (rf_rd_data)
    );

    store_unit u_store (
        .clk            (clk),
        .reset_i        (reset_i),
        .store_valid_i  (store_valid),
        .store_cmd_i    (store_cmd),
        .store_ready_o  (store_ready),
        .store_done_o   (store_done),
        .rf_rd_idx_o    (rf_rd_idx),
        .rf_rd_data_i   (rf_rd_data),
        .mem_wr_valid_o (mem_wr_valid_o),
        .mem_wr_o       (mem_wr_o),
        .mem_wr_ready_i (mem_wr_ready_i)
    );

endmodule

`default_nettype wire

//--- verif/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Program numbers
localparam int PROG_ALU  = 0;
localparam int PROG_BCD  = 1;
localparam int PROG_CTRL = 2;
localparam int PROG_IADV = 3;

// Words go to 0x200 upward, writes are listed in the order they must appear
function automatic void load_program(input int id);
    case (id)
        PROG_ALU: begin
            // ADD with carry, SUB with borrow, SUBN, OR, AND, XOR, SHR, SHL,
            // each flag copied out of VF, last ADD has x = F
            prog_q = '{16'h60F0, 16'h6120, 16'h8014, 16'h82F0, 16'h6330, 16'h6450,
                       16'h8345, 16'h85F0, 16'h6610, 16'h6730, 16'h8677, 16'h87F0,
                       16'h68C5, 16'h693C, 16'h8891, 16'h6AC5, 16'h8A92, 16'h6BC5,
                       16'h8B93, 16'h6C80, 16'h8CC6, 16'h8DF0, 16'h6EC1, 16'h8EEE,
                       16'h6FFF, 16'h8FE4, 16'hA300, 16'hFF55, 16'h1238};
            exp_q = '{20'h300_10, 20'h301_20, 20'h302_01, 20'h303_E0,
                      20'h304_50, 20'h305_00, 20'h306_20, 20'h307_01,
                      20'h308_FD, 20'h309_3C, 20'h30A_04, 20'h30B_F9,
                      20'h30C_40, 20'h30D_00, 20'h30E_82, 20'h30F_01};
        end
        PROG_BCD: begin
            // Values 0, 9, 255 and 128, three digits each
            prog_q = '{16'hA300, 16'h6000, 16'hF033, 16'hA303, 16'h6109, 16'hF133,
                       16'hA306, 16'h62FF, 16'hF233, 16'hA309, 16'h6380, 16'hF333,
                       16'h1218};
            exp_q = '{20'h300_00, 20'h301_00, 20'h302_00, 20'h303_00,
                      20'h304_00, 20'h305_09, 20'h306_02, 20'h307_05,
                      20'h308_05, 20'h309_01, 20'h30A_02, 20'h30B_08};
        end
        PROG_CTRL: begin
            // Wrong paths load EE that no later load overwrites
            // Right paths load the marker for their register
            prog_q = '{16'h6A07, 16'h6100, 16'h6200, 16'h6300, 16'h6400, 16'h6500,
                       16'h6600, 16'h3A08, 16'h6111, 16'h3A07, 16'h61EE, 16'h4A07,
                       16'h6222, 16'h4A09, 16'h62EE, 16'h6B07, 16'h9AB0, 16'h6333,
                       16'h5AB0, 16'h63EE, 16'h6444, 16'h122E, 16'h64EE, 16'h6004,
                       16'h6555, 16'hB236, 16'h65EE, 16'h65EE, 16'h65EE, 16'h2250,
                       16'h6777, 16'hA300, 16'hF755, 16'h1242, 16'h0000, 16'h0000,
                       16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h6666, 16'h00EE};
            exp_q = '{20'h300_04, 20'h301_11, 20'h302_22, 20'h303_33,
                      20'h304_44, 20'h305_55, 20'h306_66, 20'h307_77};
        end
        default: begin
            // Two block stores back to back, then I moved on by Fx1E
            prog_q = '{16'h6011, 16'h6122, 16'h6233, 16'hA300, 16'hF155, 16'hF255,
                       16'h630B, 16'hF31E, 16'hF055, 16'h1212};
            exp_q = '{20'h300_11, 20'h301_22, 20'h302_11, 20'h303_22,
                      20'h304_33, 20'h310_11};
        end
    endcase
endfunction

`endif

//--- verif/tb_chip8.sv
`timescale 1ns/1ns
`default_nettype none

module tb_chip8
    import chip8_pkg::*;
();

    // Watchdog budget per program word or write, and its safety factor
    localparam int STEP_CYCLES  = 16;
    localparam int MARGIN       = 4;
    // Quiet time after the last expected write, long enough for a few instructions
    localparam int DRAIN_CYCLES = 32;

    logic    clk;
    logic    reset;
    logic    rd_valid;
    addr_t   rd_addr;
    logic    rd_ready;
    byte_t   rd_data;
    logic    wr_valid;
    mem_wr_s wr_req;
    logic    wr_ready;

    // 4 KiB byte memory
    byte_t       mem [4096];
    logic [15:0] prog_q [$];
    mem_wr_s     exp_q [$];
    mem_wr_s     exp_head;
    logic        exp_empty = 1'b1;
    // Write on the bus at the coming rising edge
    mem_wr_s     wr_seen;
    logic        fire_pending;
    logic        stall_en;
    integer      seed = 32'hdda6_837a;
    string       cur_test = "none";
    int          check_errs = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          watchdog_cycles = 0;

    `include "tb_programs.svh"

    chip8_cpu dut0 (
        .clk            (clk),
        .reset_i        (reset),
        .mem_rd_valid_o (rd_valid),
        .mem_rd_addr_o  (rd_addr),
        .mem_rd_ready_i (rd_ready),
        .mem_rd_data_i  (rd_data),
        .mem_wr_valid_o (wr_valid),
        .mem_wr_o       (wr_req),
        .mem_wr_ready_i (wr_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Every accepted write must be expected, and must match the head entry
    a_no_extra_write: assert property (@(posedge clk) disable iff (reset)
        wr_valid && wr_ready |-> !exp_empty)
        else begin
            $display("Unexpected memory write at %03h in test %s", wr_seen.addr, cur_test);
            check_errs++;
        end
    a_write_match: assert property (@(posedge clk) disable iff (reset)
        wr_valid && wr_ready && !exp_empty |-> wr_req == exp_head)
        else begin
            $display("ERROR %s: expected %05h, actual %05h", cur_test, exp_head, wr_seen);
            check_errs++;
        end

    // Low about one cycle in four when stalls are on
    function automatic logic draw_ready();
        int r;
        if (!stall_en) begin
            return 1'b1;
        end
        r = $random(seed);
        return r[1:0] != 2'b00;
    endfunction

    function automatic void refresh_head();
        exp_empty = (exp_q.size() == 0);
        if (!exp_empty) begin
            exp_head = exp_q[0];
        end
    endfunction

    function automatic int test_cycles(input int id);
        load_program(id);
        return 5 + DRAIN_CYCLES + (prog_q.size() + exp_q.size()) * STEP_CYCLES;
    endfunction

    // Retire the write taken at the last edge, then drive the next cycle
    task automatic step_memory();
        if (fire_pending) begin
            mem[wr_seen.addr] = wr_seen.data;
            if (!exp_empty) begin
                void'(exp_q.pop_front());
            end
            fire_pending = 1'b0;
        end
        refresh_head();
        rd_ready = draw_ready();
        wr_ready = draw_ready();
        // Read data follows the address, valid whenever ready is
        rd_data  = mem[rd_addr];
        wr_seen  = wr_req;
        fire_pending = wr_valid && wr_ready;
    endtask

    task automatic run_test(input int id, input string name, input logic stalls);
        addr_t pa;
        int    errs_before;
        @(negedge clk);
        reset        = 1'b1;
        rd_ready     = 1'b1;
        wr_ready     = 1'b1;
        rd_data      = '0;
        cur_test     = name;
        stall_en     = stalls;
        fire_pending = 1'b0;
        load_program(id);
        // Fill pattern over the whole address
        for (int a = 0; a < 4096; a++) begin
            pa      = addr_t'(a);
            mem[pa] = byte_t'(a * 7) ^ byte_t'(a >> 8);
        end
        // Program words big endian from 0x200
        pa = RESET_PC;
        foreach (prog_q[k]) begin
            mem[pa]         = prog_q[k][15:8];
            mem[pa + 12'd1] = prog_q[k][7:0];
            pa              = pa + 12'd2;
        end
        refresh_head();
        errs_before = check_errs;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        // Done once every expected write is taken
        while (!exp_empty) begin
            @(negedge clk);
            step_memory();
        end
        // Keep serving the bus so a write past the list shows up
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            step_memory();
        end
        // Park the core in reset until the next program is loaded
        reset = 1'b1;
        if (check_errs == errs_before) begin
            $display("PASS %s", name);
            pass_cnt++;
        end else begin
            $display("FAIL %s: %0d failed checks", name, check_errs - errs_before);
            fail_cnt++;
        end
    endtask

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired, test %s did not finish its writes", cur_test);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        rd_ready     = 1'b1;
        rd_data      = '0;
        wr_ready     = 1'b1;
        stall_en     = 1'b0;
        fire_pending = 1'b0;
        // ALU and control programs run twice
        watchdog_cycles = MARGIN * (2 * test_cycles(PROG_ALU) + test_cycles(PROG_BCD)
            + 2 * test_cycles(PROG_CTRL) + test_cycles(PROG_IADV));
        run_test(PROG_ALU, "alu_flags", 1'b0);
        run_test(PROG_BCD, "bcd", 1'b0);
        run_test(PROG_CTRL, "control_flow", 1'b0);
        run_test(PROG_IADV, "i_advance", 1'b0);
        run_test(PROG_ALU, "alu_flags_stall", 1'b1);
        run_test(PROG_CTRL, "control_flow_stall", 1'b1);
        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verif
src/chip8_pkg.sv
src/fetch_unit.sv
src/exec_core.sv
src/store_unit.sv
src/chip8_cpu.sv
verif/tb_chip8.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the CHIP-8 CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_chip8 -Mdir "$build_dir" -o tb_chip8 -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/tb_chip8" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# The log decides the result
if grep -q "Test FAILED" "$log_file"; then
    exit 1
fi
exit 0
